/* hw/lsu_ctrl_fsm.sv */
// bus transaction controller, splits word-crossing accesses in two
// responses are assumed in order, at most two outstanding
// the core waits for lsu_resp_valid_o before starting a new access
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fsm #(
  parameter int unsigned AddrWidth = lsu_pkg::AddrWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lsu_req_i,
  input  lsu_pkg::lsu_type_e   lsu_type_i,
  input  logic                 lsu_we_i,
  input  logic [AddrWidth-1:0] lsu_addr_i,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  output logic                 data_req_o,
  output logic [AddrWidth-1:0] data_addr_o,
  output logic                 second_part_o,
  output logic                 ctrl_update_o,
  output logic                 rdata_update_o,
  output logic                 lsu_req_done_o,
  output logic                 lsu_resp_valid_o,
  output logic                 lsu_rdata_valid_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic [AddrWidth-1:0] addr_last_o,
  output logic                 busy_o
);

  lsu_pkg::ls_fsm_e     ls_fsm_cs, ls_fsm_ns;

  logic                 split_access;
  // high once the first part is granted, until the second part is granted
  logic                 handle_mis_q, handle_mis_d;
  // error seen on the first part
  logic                 lsu_err_q, lsu_err_d;
  logic                 data_we_q;
  logic                 addr_update;
  // selects the address of the second word
  logic                 addr_second;
  logic                 resp_err;
  logic [AddrWidth-1:0] addr_aligned;
  logic [AddrWidth-1:0] addr_next;
  logic [AddrWidth-1:0] addr_last_q;

  // word at nonzero offset, or halfword at offset 3
  assign split_access =
      ((lsu_type_i == lsu_pkg::LSU_WORD) && (lsu_addr_i[1:0] != 2'b00)) ||
      ((lsu_type_i == lsu_pkg::LSU_HALF) && (lsu_addr_i[1:0] == 2'b11));

  ////////////////////
  // controller
  ////////////////////

  always_comb begin
    ls_fsm_ns      = ls_fsm_cs;
    data_req_o     = 1'b0;
    addr_second    = 1'b0;
    handle_mis_d   = handle_mis_q;
    lsu_err_d      = lsu_err_q;
    addr_update    = 1'b0;
    ctrl_update_o  = 1'b0;
    rdata_update_o = 1'b0;

    unique case (ls_fsm_cs)
      lsu_pkg::LS_IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            handle_mis_d  = split_access;
            if (split_access) begin
              ls_fsm_ns = lsu_pkg::LS_WAIT_RVALID_MIS;
            end
          end else if (split_access) begin
            ls_fsm_ns = lsu_pkg::LS_WAIT_GNT_MIS;
          end else begin
            ls_fsm_ns = lsu_pkg::LS_WAIT_GNT;
          end
        end
      end

      lsu_pkg::LS_WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          handle_mis_d  = 1'b1;
          ls_fsm_ns     = lsu_pkg::LS_WAIT_RVALID_MIS;
        end
      end

      lsu_pkg::LS_WAIT_RVALID_MIS: begin
        // second request goes out while the first response is pending
        data_req_o  = 1'b1;
        addr_second = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_err_i;
          rdata_update_o = ~data_we_q;
          // last address keeps the first part when that part failed
          addr_update    = data_gnt_i & ~data_err_i;
          handle_mis_d   = ~data_gnt_i;
          ls_fsm_ns      = data_gnt_i ? lsu_pkg::LS_IDLE : lsu_pkg::LS_WAIT_GNT;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;
          ls_fsm_ns    = lsu_pkg::LS_WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      lsu_pkg::LS_WAIT_GNT: begin
        // aligned access, or second part after the first response
        data_req_o  = 1'b1;
        addr_second = handle_mis_q;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~lsu_err_q;
          handle_mis_d  = 1'b0;
          ls_fsm_ns     = lsu_pkg::LS_IDLE;
        end
      end

      lsu_pkg::LS_WAIT_RVALID_MIS_GNTS_DONE: begin
        // both granted, the last address waits for the first response
        addr_second = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_err_i;
          addr_update    = ~data_err_i;
          rdata_update_o = ~data_we_q;
          ls_fsm_ns      = lsu_pkg::LS_IDLE;
        end
      end

      default: ls_fsm_ns = lsu_pkg::LS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs    <= lsu_pkg::LS_IDLE;
      handle_mis_q <= 1'b0;
      lsu_err_q    <= 1'b0;
      data_we_q    <= 1'b0;
      addr_last_q  <= '0;
    end else begin
      ls_fsm_cs    <= ls_fsm_ns;
      handle_mis_q <= handle_mis_d;
      lsu_err_q    <= lsu_err_d;
      if (ctrl_update_o) begin
        data_we_q <= lsu_we_i;
      end
      // byte address for the first part, word address for the second
      if (addr_update) begin
        addr_last_q <= addr_second ? addr_next : lsu_addr_i;
      end
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  assign addr_aligned = {lsu_addr_i[AddrWidth-1:2], 2'b00};
  assign addr_next    = addr_aligned + AddrWidth'(4);
  assign data_addr_o  = addr_second ? addr_next : addr_aligned;

  assign second_part_o = handle_mis_q;
  assign addr_last_o   = addr_last_q;
  assign busy_o        = (ls_fsm_cs != lsu_pkg::LS_IDLE);

  // done once no further grant is needed for this access
  assign lsu_req_done_o = (lsu_req_i | busy_o) & (ls_fsm_ns == lsu_pkg::LS_IDLE);

  // the final response always lands in LS_IDLE
  assign resp_err          = lsu_err_q | data_err_i;
  assign lsu_resp_valid_o  = data_rvalid_i & (ls_fsm_cs == lsu_pkg::LS_IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~data_we_q;
  assign load_err_o        = lsu_resp_valid_o & resp_err & ~data_we_q;
  assign store_err_o       = lsu_resp_valid_o & resp_err & data_we_q;

endmodule

`default_nettype wire

/* hw/lsu_load_align.sv */
// load data realignment and zero or sign extension
// attributes are captured when the controller flags the access
// the output is combinational from the bus read data
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align #(
  parameter int unsigned DataWidth = lsu_pkg::DataWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ctrl_update_i,
  input  logic                 rdata_update_i,
  input  logic [1:0]           addr_offset_i,
  input  lsu_pkg::lsu_type_e   lsu_type_i,
  input  logic                 lsu_sign_ext_i,
  input  logic [DataWidth-1:0] data_rdata_i,
  output logic [DataWidth-1:0] lsu_rdata_o
);

  // registered access attributes
  logic [1:0]           offset_q;
  lsu_pkg::lsu_type_e   type_q;
  logic                 sign_ext_q;

  // upper three bytes of the first-part word
  logic [DataWidth-1:8] rdata_q;

  logic [DataWidth-1:0] rdata_w;
  logic [DataWidth-1:0] rdata_shift;
  logic [15:0]          rdata_h;
  logic [7:0]           rdata_b;

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      type_q     <= lsu_pkg::LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= addr_offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  // lane 0 of the first word is never part of a split access
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[DataWidth-1:8];
    end
  end

  ////////////////////
  // realignment
  ////////////////////

  // word rebuilt from held upper bytes and low bytes of the current word
  always_comb begin
    unique case (offset_q)
      2'b00: rdata_w = data_rdata_i;
      2'b01: rdata_w = {data_rdata_i[7:0], rdata_q[DataWidth-1:8]};
      2'b10: rdata_w = {data_rdata_i[15:0], rdata_q[DataWidth-1:16]};
      default: rdata_w = {data_rdata_i[23:0], rdata_q[DataWidth-1:24]};
    endcase
  end

  // accesses inside one word just shift down by the offset
  assign rdata_shift = data_rdata_i >> {offset_q, 3'b000};

  // a halfword at offset 3 straddles two words, same bytes as the word case
  assign rdata_h = (offset_q == 2'b11) ? rdata_w[15:0] : rdata_shift[15:0];
  assign rdata_b = rdata_shift[7:0];

  ////////////////////
  // extension
  ////////////////////

  always_comb begin
    unique case (type_q)
      lsu_pkg::LSU_WORD: lsu_rdata_o = rdata_w;
      lsu_pkg::LSU_HALF: lsu_rdata_o = {{(DataWidth-16){sign_ext_q & rdata_h[15]}}, rdata_h};
      default:           lsu_rdata_o = {{(DataWidth-8){sign_ext_q & rdata_b[7]}}, rdata_b};
    endcase
  end

endmodule

`default_nettype wire

/* hw/lsu_pkg.sv */
// widths and encodings shared by the load/store unit blocks
// the datapath assumes a 32-bit word with four byte lanes
`default_nettype none

package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////

  // byte address width
  parameter int unsigned AddrWidth = 32;

  // bus and register data width
  parameter int unsigned DataWidth = 32;

  // byte lanes per bus word
  parameter int unsigned BeWidth = DataWidth / 8;

  ////////////////////
  // encodings
  ////////////////////

  // access size as issued by the core
  // code 2'b11 is treated as a byte as well
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // transaction controller states
  // the _MIS states belong to an access split into two words
  typedef enum logic [2:0] {
    LS_IDLE,
    LS_WAIT_GNT_MIS,
    LS_WAIT_RVALID_MIS,
    LS_WAIT_GNT,
    LS_WAIT_RVALID_MIS_GNTS_DONE
  } ls_fsm_e;

endpackage

`default_nettype wire

/* hw/lsu_store_align.sv */
// byte enables and store data lane placement, purely combinational
// the byte enable width follows lsu_pkg::BeWidth, so DataWidth stays 32
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align #(
  parameter int unsigned DataWidth = lsu_pkg::DataWidth
) (
  input  lsu_pkg::lsu_type_e          lsu_type_i,
  input  logic [1:0]                  addr_offset_i,
  input  logic                        second_part_i,
  input  logic [DataWidth-1:0]        lsu_wdata_i,
  output logic [lsu_pkg::BeWidth-1:0] data_be_o,
  output logic [DataWidth-1:0]        data_wdata_o
);

  localparam int unsigned Lanes = lsu_pkg::BeWidth;

  // lanes covered by the access when it sits at offset 0
  logic [Lanes-1:0]       be_base;
  // lanes over two consecutive words after shifting by the offset
  logic [2*Lanes-1:0]     be_span;
  // offset in bits
  logic [4:0]             rot_amt;
  // write data placed twice so a shift acts as a rotation
  logic [2*DataWidth-1:0] wdata_dbl;

  ////////////////////
  // byte enables
  ////////////////////

  always_comb begin
    unique case (lsu_type_i)
      lsu_pkg::LSU_WORD: be_base = '1;
      lsu_pkg::LSU_HALF: be_base = Lanes'(2'b11);
      // byte, and the unused fourth code
      default:           be_base = Lanes'(1'b1);
    endcase
  end

  // low half is the first word, high half is what spills into the next word
  assign be_span = {{Lanes{1'b0}}, be_base} << addr_offset_i;

  // bytes never spill, so their high half is always zero
  assign data_be_o = second_part_i ? be_span[2*Lanes-1:Lanes] : be_span[Lanes-1:0];

  ////////////////////
  // write data
  ////////////////////

  assign rot_amt = {addr_offset_i, 3'b000};

  // rotate left by the offset
  // each byte then sits in its own lane for the first and the second part
  assign wdata_dbl    = {lsu_wdata_i, lsu_wdata_i} << rot_amt;
  assign data_wdata_o = wdata_dbl[2*DataWidth-1:DataWidth];

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
// load/store unit between a core stage and a req/gnt/rvalid data bus
// core holds the request until lsu_req_done_o and waits for lsu_resp_valid_o
// DataWidth must match lsu_pkg::BeWidth lanes, i.e. 32 bits
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int unsigned AddrWidth = lsu_pkg::AddrWidth,
  parameter int unsigned DataWidth = lsu_pkg::DataWidth
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // core side
  input  logic                        lsu_req_i,
  input  logic                        lsu_we_i,
  input  lsu_pkg::lsu_type_e          lsu_type_i,
  input  logic                        lsu_sign_ext_i,
  input  logic [AddrWidth-1:0]        lsu_addr_i,
  input  logic [DataWidth-1:0]        lsu_wdata_i,
  output logic [DataWidth-1:0]        lsu_rdata_o,
  output logic                        lsu_rdata_valid_o,
  output logic                        lsu_resp_valid_o,
  output logic                        lsu_req_done_o,
  output logic                        load_err_o,
  output logic                        store_err_o,
  output logic [AddrWidth-1:0]        addr_last_o,
  output logic                        busy_o,

  // data bus
  output logic                        data_req_o,
  input  logic                        data_gnt_i,
  output logic [AddrWidth-1:0]        data_addr_o,
  output logic                        data_we_o,
  output logic [lsu_pkg::BeWidth-1:0] data_be_o,
  output logic [DataWidth-1:0]        data_wdata_o,
  input  logic                        data_rvalid_i,
  input  logic                        data_err_i,
  input  logic [DataWidth-1:0]        data_rdata_i
);

  logic [1:0] addr_offset;
  logic       second_part;
  logic       ctrl_update;
  logic       rdata_update;

  // byte offset inside the word, held stable by the core
  assign addr_offset = lsu_addr_i[1:0];
  assign data_we_o   = lsu_we_i;

  lsu_ctrl_fsm #(
    .AddrWidth (AddrWidth)
  ) u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_type_i        (lsu_type_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_addr_i        (lsu_addr_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_req_o        (data_req_o),
    .data_addr_o       (data_addr_o),
    .second_part_o     (second_part),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .addr_last_o       (addr_last_o),
    .busy_o            (busy_o)
  );

  lsu_store_align #(
    .DataWidth (DataWidth)
  ) u_store_align (
    .lsu_type_i    (lsu_type_i),
    .addr_offset_i (addr_offset),
    .second_part_i (second_part),
    .lsu_wdata_i   (lsu_wdata_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_load_align #(
    .DataWidth (DataWidth)
  ) u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .addr_offset_i  (addr_offset),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

`default_nettype wire

/* lsu.f */
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_load_align.sv
hw/lsu_ctrl_fsm.sv
hw/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build the load/store unit testbench with Verilator and run it
# the run passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
  --top-module lsu_tb -f lsu.f -o lsu_sim \
  && ./obj_dir/lsu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "build or simulation ended with an error status" >> sim.log

cat sim.log
grep -qx '>>> PASS' sim.log && exit 0 || exit 1

/* tests/lsu_checker.sv */
// bus protocol and controller assertions, bound into lsu_ctrl_fsm
// fail_cnt counts the assertion failures of the run
`timescale 1ns/1ps
`default_nettype none

module lsu_checker #(
  parameter int unsigned AddrWidth = lsu_pkg::AddrWidth
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 data_req_o,
  input logic                 data_gnt_i,
  input logic [AddrWidth-1:0] data_addr_o,
  input logic                 lsu_we_i,
  input logic                 second_part_o,
  input lsu_pkg::ls_fsm_e     ls_fsm_cs,
  input logic                 busy_o
);

  int unsigned fail_cnt = 0;

  // bus only ever sees word addresses
  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_req_o |-> (data_addr_o[1:0] == 2'b00))
    else begin
      fail_cnt++;
      $error("bus address not word aligned while a request is pending");
    end

  // a waiting request keeps address, direction and part until granted
  // the part selects the byte enables and the lane of the store data
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (data_req_o && !data_gnt_i) |=>
          (data_req_o && $stable(data_addr_o) && $stable(lsu_we_i) &&
           $stable(second_part_o)))
    else begin
      fail_cnt++;
      $error("request dropped or its fields changed before its grant");
    end

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ls_fsm_cs inside {lsu_pkg::LS_IDLE, lsu_pkg::LS_WAIT_GNT_MIS,
                        lsu_pkg::LS_WAIT_RVALID_MIS, lsu_pkg::LS_WAIT_GNT,
                        lsu_pkg::LS_WAIT_RVALID_MIS_GNTS_DONE})
    else begin
      fail_cnt++;
      $error("controller state is not a legal encoding");
    end

  // controller comes out of reset idle
  a_idle_after_reset: assert property (@(posedge clk_i) !rst_ni |=> !busy_o)
    else begin
      fail_cnt++;
      $error("busy high in the first cycle after reset");
    end

endmodule

bind lsu_ctrl_fsm lsu_checker #(
  .AddrWidth (AddrWidth)
) u_checker (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .data_req_o    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_addr_o   (data_addr_o),
  .lsu_we_i      (lsu_we_i),
  .second_part_o (second_part_o),
  .ls_fsm_cs     (ls_fsm_cs),
  .busy_o        (busy_o)
);

`default_nettype wire

/* tests/lsu_tb.sv */
// testbench for lsu_top with a 256-word memory model behind the data bus
// word addresses with bit 9 set answer with a bus error and drop writes
// one access at a time, the next starts after the response
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int unsigned AddrWidth   = lsu_pkg::AddrWidth;
  localparam int unsigned DataWidth   = lsu_pkg::DataWidth;
  localparam int unsigned MemWords    = 256;
  localparam int unsigned NumDirected = 16 + 34 + 16 + 6;
  localparam int unsigned NumRandom   = 300;
  // 40 cycles per access plus some room for reset
  localparam int unsigned CycleLimit  = 40 * (NumDirected + NumRandom) + 20;

  logic                        clk_i, rst_ni;
  logic                        lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  lsu_pkg::lsu_type_e          lsu_type_i;
  logic [AddrWidth-1:0]        lsu_addr_i, addr_last_o, data_addr_o;
  logic [DataWidth-1:0]        lsu_wdata_i, lsu_rdata_o, data_wdata_o;
  logic                        lsu_rdata_valid_o, lsu_resp_valid_o, lsu_req_done_o;
  logic                        load_err_o, store_err_o, busy_o, data_req_o, data_we_o;
  logic [lsu_pkg::BeWidth-1:0] data_be_o;
  logic                        data_gnt_i    = 1'b0;
  logic                        data_rvalid_i = 1'b0;
  logic                        data_err_i    = 1'b0;
  logic [DataWidth-1:0]        data_rdata_i  = '0;

  // memory model state and in-order response queue
  logic [DataWidth-1:0] mem [MemWords];
  logic [7:0]           shadow [4*MemWords];
  logic [DataWidth-1:0] rsp_data_q [$];
  logic                 rsp_err_q [$];
  int unsigned          rsp_due_q [$];
  int unsigned          mem_cycle = 0, last_due = 0, gnt_wait = 0;

  // expected response of the access in flight
  logic                 exp_we, exp_err;
  logic [DataWidth-1:0] exp_data;
  logic [AddrWidth-1:0] exp_last;
  int unsigned          cmp_errors = 0, seq_errors = 0, checks = 0, issued = 0;
  int unsigned          done_cnt = 0, resp_cnt = 0, busy_cnt = 0, cycle_cnt = 0;

  lsu_top #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // initial memory word, a function of the whole word index
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return ((idx + 32'd1) * 32'h9E37_79B9) ^ (idx << 20);
  endfunction

  // expected load value from the byte shadow
  function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [1:0] size,
                                           input logic sext);
    logic [9:0]  base;
    logic [31:0] val;
    base = addr[9:0];
    val  = {shadow[base + 10'd3], shadow[base + 10'd2], shadow[base + 10'd1], shadow[base]};
    case (size)
      2'b00:   return val;
      2'b01:   return {{16{sext & val[15]}}, val[15:0]};
      default: return {{24{sext & val[7]}}, val[7:0]};
    endcase
  endfunction

  // bytes in error words are not written
  task automatic update_shadow(input logic [31:0] addr, input logic [1:0] size,
                               input logic [31:0] wdata);
    int unsigned nbytes;
    logic [9:0]  a;
    nbytes = (size == 2'b00) ? 4 : ((size == 2'b01) ? 2 : 1);
    for (int unsigned i = 0; i < nbytes; i++) begin
      a = addr[9:0] + 10'(i);
      if (!a[9]) shadow[a] = wdata[8*i +: 8];
    end
  endtask

  task automatic do_access(input logic we, input logic [1:0] size, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic sext);
    int unsigned done_base, resp_base, busy_base;
    logic        split;
    logic [31:0] second_word;
    split       = ((size == 2'b00) && (addr[1:0] != 2'b00)) ||
                  ((size == 2'b01) && (addr[1:0] == 2'b11));
    second_word = {addr[31:2], 2'b00} + 32'd4;
    exp_we      = we;
    exp_err     = addr[9] || (split && second_word[9]);
    // first part error keeps the byte address, else a split ends on the second word
    exp_last    = (addr[9] || !split) ? addr : second_word;
    if (we) update_shadow(addr, size, wdata);
    else exp_data = ref_load(addr, size, sext);
    done_base = done_cnt;
    resp_base = resp_cnt;
    busy_base = busy_cnt;
    lsu_req_i      <= 1'b1;
    lsu_we_i       <= we;
    lsu_type_i     <= lsu_pkg::lsu_type_e'(size);
    lsu_addr_i     <= addr;
    lsu_wdata_i    <= wdata;
    lsu_sign_ext_i <= sext;
    do @(posedge clk_i); while (!lsu_req_done_o);
    lsu_req_i <= 1'b0;
    while (!lsu_resp_valid_o) @(posedge clk_i);
    @(posedge clk_i);
    assert ((done_cnt - done_base == 1) && (resp_cnt - resp_base == 1)) else begin
      seq_errors++;
      $display("Error: %0t: addr %h saw %0d done and %0d resp pulses, expected one each",
               $time, addr, done_cnt - done_base, resp_cnt - resp_base);
    end
    // a split access always leaves idle between its two grants
    assert (!split || (busy_cnt != busy_base)) else begin
      seq_errors++;
      $display("Error: %0t: split access at addr %h never raised busy", $time, addr);
    end
    issued++;
  endtask

  ////////////////////
  // memory model
  ////////////////////

  always @(posedge clk_i) begin
    logic [7:0] widx;
    int unsigned due;
    if (!rst_ni) begin
      for (int unsigned i = 0; i < MemWords; i++) mem[i] = fill_word(i);
      data_gnt_i    <= 1'b0;
      data_rvalid_i <= 1'b0;
    end else begin
      mem_cycle++;
      if (data_req_o && data_gnt_i) begin
        widx = data_addr_o[9:2];
        rsp_data_q.push_back(mem[widx]);
        rsp_err_q.push_back(data_addr_o[9]);
        if (data_we_o && !data_addr_o[9]) begin
          for (int b = 0; b < 4; b++) begin
            if (data_be_o[b]) mem[widx][8*b +: 8] = data_wdata_o[8*b +: 8];
          end
        end
        // response one to three cycles after the grant, kept in order
        due = mem_cycle + ($urandom % 3);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        rsp_due_q.push_back(due);
        gnt_wait = $urandom % 4;
      end else if (data_req_o && gnt_wait > 0) begin
        gnt_wait--;
      end
      data_gnt_i <= (gnt_wait == 0);
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= mem_cycle) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= rsp_data_q.pop_front();
        data_err_i    <= rsp_err_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        data_rvalid_i <= 1'b0;
        data_err_i    <= 1'b0;
        data_rdata_i  <= '0;
      end
    end
  end

  ////////////////////
  // compare
  ////////////////////

  always @(posedge clk_i) begin
    if (rst_ni && lsu_req_done_o) done_cnt++;
    if (rst_ni && busy_o) busy_cnt++;
    // data valid and error flags only ever come with the response
    if (rst_ni && !lsu_resp_valid_o) begin
      assert (!lsu_rdata_valid_o && !load_err_o && !store_err_o) else begin
        cmp_errors++;
        $display("Error: %0t: rdata_valid or an error flag high without resp_valid", $time);
      end
    end
    if (rst_ni && lsu_resp_valid_o) begin
      resp_cnt++;
      checks++;
      assert (lsu_rdata_valid_o == (!exp_we && !exp_err)) else begin
        cmp_errors++;
        $display("Error: %0t: rdata_valid %b, expected %b", $time, lsu_rdata_valid_o,
                 !exp_we && !exp_err);
      end
      assert ((load_err_o == (!exp_we && exp_err)) && (store_err_o == (exp_we && exp_err)))
      else begin
        cmp_errors++;
        $display("Error: %0t: load_err %b store_err %b, expected error %b on a %s", $time,
                 load_err_o, store_err_o, exp_err, exp_we ? "store" : "load");
      end
      assert (!lsu_rdata_valid_o || (lsu_rdata_o == exp_data)) else begin
        cmp_errors++;
        $display("Error: %0t: load data %h, expected %h", $time, lsu_rdata_o, exp_data);
      end
      assert (addr_last_o == exp_last) else begin
        cmp_errors++;
        $display("Error: %0t: addr_last %h, expected %h", $time, addr_last_o, exp_last);
      end
      // all grants and the first response are behind, so the controller is idle
      assert (!busy_o) else begin
        cmp_errors++;
        $display("Error: %0t: busy high with the final response", $time);
      end
    end
  end

  // hang guard
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("timeout: no progress within %0d cycles, an access never completed", CycleLimit);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [31:0] base;
    logic [31:0] mis_addr [4];
    logic [1:0]  mis_size [4];
    int unsigned total;
    mis_addr = '{32'h0A1, 32'h0B2, 32'h0C3, 32'h0D3};
    mis_size = '{2'b00, 2'b00, 2'b00, 2'b01};
    void'($urandom(78));
    rst_ni         <= 1'b0;
    lsu_req_i      <= 1'b0;
    lsu_we_i       <= 1'b0;
    lsu_type_i     <= lsu_pkg::LSU_WORD;
    lsu_sign_ext_i <= 1'b0;
    lsu_addr_i     <= '0;
    lsu_wdata_i    <= '0;
    for (int unsigned i = 0; i < MemWords; i++) begin
      for (int unsigned b = 0; b < 4; b++) shadow[4*i + b] = 8'(fill_word(i) >> (8*b));
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // aligned words, stored then read back
    for (int unsigned i = 0; i < 8; i++) do_access(1'b1, 2'b00, 32'h040 + 8*i, $urandom, 1'b0);
    for (int unsigned i = 0; i < 8; i++) do_access(1'b0, 2'b00, 32'h040 + 8*i, '0, 1'b0);

    // bytes and halfwords at every offset, both extensions
    for (int unsigned w = 0; w < 2; w++) begin
      base = (w == 0) ? 32'h100 : 32'h180;
      do_access(1'b1, 2'b00, base, (w == 0) ? 32'h80FF_7F81 : 32'h7F80_01FE, 1'b0);
      for (int unsigned off = 0; off < 4; off++) begin
        for (int s = 0; s < 2; s++) begin
          do_access(1'b0, 2'b10, base + off, '0, 1'(s));
          do_access(1'b0, 2'b01, base + off, '0, 1'(s));
        end
      end
    end

    // split stores, checked word by word and through a split load
    for (int i = 0; i < 4; i++) begin
      do_access(1'b1, mis_size[i], mis_addr[i], $urandom, 1'b0);
      do_access(1'b0, 2'b00, {mis_addr[i][31:2], 2'b00}, '0, 1'b0);
      do_access(1'b0, 2'b00, {mis_addr[i][31:2], 2'b00} + 32'd4, '0, 1'b0);
      do_access(1'b0, mis_size[i], mis_addr[i], '0, 1'b0);
    end

    // bus errors on the first part, the second part, and a partial store
    do_access(1'b0, 2'b00, 32'h200, '0, 1'b0);
    do_access(1'b1, 2'b00, 32'h204, 32'h1234_5678, 1'b0);
    do_access(1'b0, 2'b00, 32'h1FE, '0, 1'b0);
    do_access(1'b1, 2'b01, 32'h1FF, 32'h0000_A55A, 1'b0);
    do_access(1'b0, 2'b00, 32'h3FD, '0, 1'b0);
    do_access(1'b0, 2'b10, 32'h1FF, '0, 1'b0);

    // mixed random traffic under random back-pressure
    for (int unsigned n = 0; n < NumRandom; n++) begin
      do_access(1'($urandom % 2), 2'($urandom % 4), $urandom % 1024, $urandom,
                1'($urandom % 2));
    end

    total = cmp_errors + seq_errors + DUT.u_ctrl_fsm.u_checker.fail_cnt;
    $display("accesses %0d, checked %0d, errors %0d (compare %0d, count %0d, assert %0d)",
             issued, checks, total, cmp_errors, seq_errors, DUT.u_ctrl_fsm.u_checker.fail_cnt);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
